// File: Makefile
# Verilator build and run for the reservation station testbench

VERILATOR ?= verilator
TOP       ?= super_rs_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation PASSED

SOURCES := $(FILELIST) $(wildcard verilog/*.sv bench/*.sv bench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(BIN)
	-$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/super_rs_props.sv
`timescale 1ns/1ps

module super_rs_props (
  input logic                                     clk,
  input logic                                     reset,
  input logic [rs_pkg::scalar-1:0]                en_out,
  input logic [rs_pkg::scalar*rs_pkg::rs_idx-1:0] rs_idx_out,
  input rs_pkg::fu_class_t [rs_pkg::scalar-1:0]   fu_class_out,
  input logic [rs_pkg::rs_sz-1:0]                 busy0,
  input logic [rs_pkg::rs_sz-1:0]                 busy1,
  input logic [rs_pkg::scalar-1:0]                exfu_free,
  input logic [rs_pkg::scalar-1:0]                memfu_free,
  input logic [rs_pkg::scalar-1:0]                multfu_free
);
  import rs_pkg::*;

  logic [scalar-1:0] unit_free [scalar];  // Free bits of the class each bank issues

  always_comb begin
    for (int b = 0; b < scalar; b++) begin
      case (fu_class_out[b])
        fu_mult: unit_free[b] = multfu_free;
        fu_mem:  unit_free[b] = memfu_free;
        default: unit_free[b] = exfu_free;
      endcase
    end
  end

  // Entries are cleared after the first reset edge
  quiet_in_reset: assert property (@(posedge clk) reset && $past(reset) |-> en_out == '0)
    else $error("en_out set during reset");

  issue0_busy: assert property (@(posedge clk) disable iff (reset)
    en_out[0] |-> busy0[rs_idx_out[1:0]])
    else $error("bank 0 issued a free entry");

  issue1_busy: assert property (@(posedge clk) disable iff (reset)
    en_out[1] |-> busy1[rs_idx_out[3:2]])
    else $error("bank 1 issued a free entry");

  // Bank 0 only ever sees unit 0
  issue0_unit: assert property (@(posedge clk) disable iff (reset)
    en_out[0] |-> unit_free[0][0])
    else $error("bank 0 issued while its unit was busy");

  issue1_unit: assert property (@(posedge clk) disable iff (reset)
    en_out[1] |-> |unit_free[1])
    else $error("bank 1 issued while every unit of its class was busy");

  shared_unit: assert property (@(posedge clk) disable iff (reset)
    en_out[0] && en_out[1] && fu_class_out[0] == fu_class_out[1] |-> &unit_free[1])
    else $error("both banks issued one class without two free units");

endmodule

bind super_rs super_rs_props u_props (
  .clk          (clk),
  .reset        (reset),
  .en_out       (en_out),
  .rs_idx_out   (rs_idx_out),
  .fu_class_out (fu_class_out),
  .busy0        (rs0.busy),
  .busy1        (rs1.busy),
  .exfu_free    (exfu_free),
  .memfu_free   (memfu_free),
  .multfu_free  (multfu_free)
);

// File: bench/rs_model.svh
`ifndef RS_MODEL_SVH
`define RS_MODEL_SVH

// Reference state, indexed by bank then entry
logic                 m_busy [scalar][rs_sz];
logic                 m_av   [scalar][rs_sz];
logic                 m_bv   [scalar][rs_sz];
fu_class_t            m_cls  [scalar][rs_sz];
logic [prf_idx-1:0]   m_pa   [scalar][rs_sz];
logic [prf_idx-1:0]   m_pb   [scalar][rs_sz];
logic [prf_idx-1:0]   m_pd   [scalar][rs_sz];
logic [alu_op_w-1:0]  m_op   [scalar][rs_sz];
logic                 m_rd   [scalar][rs_sz];
logic                 m_wr   [scalar][rs_sz];
logic [31:0]          m_ir   [scalar][rs_sz];
logic [63:0]          m_npc  [scalar][rs_sz];
logic [rob_idx_w-1:0] m_rob  [scalar][rs_sz];

// Predicted outputs for the current cycle
logic exp_en   [scalar];
logic exp_free [scalar];
logic exp_load [scalar];
int   exp_idx  [scalar];
int   exp_slot [scalar];
int   alloc_at [scalar];

function automatic logic tag_seen(input logic [prf_idx-1:0] tag);
  return (cdb_valid[0] && cdb_tag[0 +: prf_idx] == tag) ||
         (cdb_valid[1] && cdb_tag[prf_idx +: prf_idx] == tag);
endfunction

function automatic fu_class_t class_of(input int s);
  if (rd_mem[s] || wr_mem[s]) return fu_mem;
  if (alu_op[s*alu_op_w +: alu_op_w] == op_mulq) return fu_mult;
  return fu_alu;
endfunction

// Ready and not being flushed this cycle
function automatic logic eligible(input int b, input int i);
  return m_busy[b][i] && m_av[b][i] && m_bv[b][i] && !entry_flush[b*rs_sz+i];
endfunction

function automatic logic has_class(input int b, input fu_class_t c);
  for (int i = 0; i < rs_sz; i++) begin
    if (eligible(b, i) && m_cls[b][i] == c) return 1'b1;
  end
  return 1'b0;
endfunction

task automatic clear_model();
  for (int b = 0; b < scalar; b++) begin
    for (int i = 0; i < rs_sz; i++) begin
      m_busy[b][i] = 1'b0;
      m_av[b][i]   = 1'b0;
      m_bv[b][i]   = 1'b0;
    end
  end
endtask

task automatic predict_outputs();
  logic              offer [scalar][3];
  logic [scalar-1:0] unit_free [3];
  fu_class_t         pick;
  unit_free[0] = exfu_free;
  unit_free[1] = memfu_free;
  unit_free[2] = multfu_free;
  // Unit 1 of a class only when bank 0 already holds unit 0
  for (int c = 0; c < 3; c++) begin
    offer[0][c] = unit_free[c][0] && has_class(0, fu_class_t'(c));
    offer[1][c] = (offer[0][c] ? unit_free[c][1] : unit_free[c][0]) &&
                  has_class(1, fu_class_t'(c));
  end
  for (int b = 0; b < scalar; b++) begin
    exp_free[b] = 1'b0;
    alloc_at[b] = 0;
    for (int i = rs_sz - 1; i >= 0; i--) begin
      if (!m_busy[b][i]) begin
        exp_free[b] = 1'b1;
        alloc_at[b] = i;
      end
    end
    pick = offer[b][2] ? fu_mult : (offer[b][1] ? fu_mem : fu_alu);
    exp_en[b]  = offer[b][0] || offer[b][1] || offer[b][2];
    exp_idx[b] = 0;
    for (int i = rs_sz - 1; i >= 0; i--) begin
      if (eligible(b, i) && m_cls[b][i] == pick) exp_idx[b] = i;
    end
  end
  exp_load[0] = exp_free[0] && inst_valid[0];
  exp_load[1] = exp_free[1] && (inst_valid[1] || (inst_valid[0] && !exp_free[0]));
  exp_slot[0] = 0;
  exp_slot[1] = exp_free[0] ? 1 : 0;
endtask

task automatic advance_model();
  int s;
  for (int b = 0; b < scalar; b++) begin
    for (int i = 0; i < rs_sz; i++) begin
      if (entry_flush[b*rs_sz+i] || (exp_en[b] && exp_idx[b] == i)) begin
        m_busy[b][i] = 1'b0;  // Flush beats a load into the same entry
      end else if (exp_load[b] && alloc_at[b] == i) begin
        s = exp_slot[b];
        m_busy[b][i] = 1'b1;
        m_pa[b][i]   = prega_idx[s*prf_idx +: prf_idx];
        m_pb[b][i]   = pregb_idx[s*prf_idx +: prf_idx];
        m_av[b][i]   = prega_valid[s] || tag_seen(m_pa[b][i]);
        m_bv[b][i]   = pregb_valid[s] || tag_seen(m_pb[b][i]);
        m_pd[b][i]   = pdest_idx[s*prf_idx +: prf_idx];
        m_op[b][i]   = alu_op[s*alu_op_w +: alu_op_w];
        m_rd[b][i]   = rd_mem[s];
        m_wr[b][i]   = wr_mem[s];
        m_ir[b][i]   = rs_ir[s*32 +: 32];
        m_npc[b][i]  = npc[s*64 +: 64];
        m_rob[b][i]  = rob_idx[s*rob_idx_w +: rob_idx_w];
        m_cls[b][i]  = class_of(s);
      end else if (m_busy[b][i]) begin
        m_av[b][i] = m_av[b][i] || tag_seen(m_pa[b][i]);
        m_bv[b][i] = m_bv[b][i] || tag_seen(m_pb[b][i]);
      end
    end
  end
endtask

`endif

// File: bench/super_rs_tb.sv
`timescale 1ns/1ps

module super_rs_tb;
  import rs_pkg::*;

  localparam int n_cycles   = 3000;
  localparam int clk_period = 40;

  logic                          clk, reset;
  logic [scalar-1:0]             inst_valid, prega_valid, pregb_valid, rd_mem, wr_mem;
  logic [scalar*prf_idx-1:0]     prega_idx, pregb_idx, pdest_idx, cdb_tag;
  logic [scalar*alu_op_w-1:0]    alu_op;
  logic [scalar*32-1:0]          rs_ir;
  logic [scalar*64-1:0]          npc;
  logic [scalar*rob_idx_w-1:0]   rob_idx;
  logic [scalar-1:0]             exfu_free, memfu_free, multfu_free, cdb_valid;
  logic [scalar*rs_sz-1:0]       entry_flush;
  logic [scalar-1:0]             rs_stall, en_out, rd_mem_out, wr_mem_out;
  fu_class_t [scalar-1:0]        fu_class_out;
  logic [scalar*prf_idx-1:0]     pdest_idx_out, prega_idx_out, pregb_idx_out;
  logic [scalar*alu_op_w-1:0]    alu_op_out;
  logic [scalar*32-1:0]          rs_ir_out;
  logic [scalar*64-1:0]          npc_out;
  logic [scalar*rob_idx_w-1:0]   rob_idx_out;
  logic [scalar*rs_idx-1:0]      rs_idx_out;
  logic [15:0]                   lfsr;
  int                            issued;

  `include "rs_model.svh"

  super_rs dut (.*);

  always #(clk_period/2) clk = ~clk;

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] take(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic logic unit_bit(input logic slow);
    return slow ? (take(3) == 64'd0) : (take(2) != 64'd0);
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "DUT output differs from the model");
    end
  endtask

  task automatic drive_inputs(input int cyc);
    logic       free0, free1, slow, flushing;
    logic [1:0] k;
    free0 = 1'b0;
    free1 = 1'b0;
    for (int i = 0; i < rs_sz; i++) begin
      free0 |= !m_busy[0][i];
      free1 |= !m_busy[1][i];
    end
    slow     = (cyc / 300) % 3 == 1;  // Units mostly busy, banks fill up
    flushing = cyc >= 900;
    inst_valid[0] = (take(1) != 64'd0) && (free0 || free1);
    inst_valid[1] = (take(1) != 64'd0) && free0 && free1;  // Needs both banks open
    for (int s = 0; s < scalar; s++) begin
      k = 2'(take(2));
      prega_idx[s*prf_idx +: prf_idx]     = 6'(take(3));  // Small tag range
      pregb_idx[s*prf_idx +: prf_idx]     = 6'(take(3));
      pdest_idx[s*prf_idx +: prf_idx]     = 6'(take(6));
      prega_valid[s]                      = 1'(take(1));
      pregb_valid[s]                      = 1'(take(1));
      alu_op[s*alu_op_w +: alu_op_w]      = (k == 2'd0) ? op_mulq : 5'(take(5));
      rd_mem[s]                           = k == 2'd1;
      wr_mem[s]                           = (k == 2'd2) && (take(1) != 64'd0);
      rs_ir[s*32 +: 32]                   = 32'(take(32));
      npc[s*64 +: 64]                     = take(64);
      rob_idx[s*rob_idx_w +: rob_idx_w]   = 5'(take(5));
      exfu_free[s]                        = unit_bit(slow);
      memfu_free[s]                       = unit_bit(slow);
      multfu_free[s]                      = unit_bit(slow);
      cdb_valid[s]                        = 1'(take(1));
      cdb_tag[s*prf_idx +: prf_idx]       = 6'(take(3));
    end
    for (int e = 0; e < scalar*rs_sz; e++) begin
      entry_flush[e] = flushing && (take(5) == 64'd0);
    end
  endtask

  task automatic compare_outputs();
    string sfx;
    int    i;
    for (int b = 0; b < scalar; b++) begin
      sfx = $sformatf("[%0d]", b);
      check(64'(rs_stall[b]), 64'(!exp_free[b]), {"rs_stall", sfx});
      check(64'(en_out[b]), 64'(exp_en[b]), {"en_out", sfx});
      if (exp_en[b]) begin
        i = exp_idx[b];
        issued++;
        check(64'(rs_idx_out[b*rs_idx +: rs_idx]), 64'(i), {"rs_idx_out", sfx});
        check(64'(fu_class_out[b]), 64'(m_cls[b][i]), {"fu_class_out", sfx});
        check(64'(pdest_idx_out[b*prf_idx +: prf_idx]), 64'(m_pd[b][i]), {"pdest", sfx});
        check(64'(prega_idx_out[b*prf_idx +: prf_idx]), 64'(m_pa[b][i]), {"prega", sfx});
        check(64'(pregb_idx_out[b*prf_idx +: prf_idx]), 64'(m_pb[b][i]), {"pregb", sfx});
        check(64'(alu_op_out[b*alu_op_w +: alu_op_w]), 64'(m_op[b][i]), {"alu_op", sfx});
        check(64'(rd_mem_out[b]), 64'(m_rd[b][i]), {"rd_mem_out", sfx});
        check(64'(wr_mem_out[b]), 64'(m_wr[b][i]), {"wr_mem_out", sfx});
        check(64'(rs_ir_out[b*32 +: 32]), 64'(m_ir[b][i]), {"rs_ir_out", sfx});
        check(npc_out[b*64 +: 64], m_npc[b][i], {"npc_out", sfx});
        check(64'(rob_idx_out[b*rob_idx_w +: rob_idx_w]), 64'(m_rob[b][i]), {"rob_idx", sfx});
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    lfsr        = 16'd17959;
    issued      = 0;
    inst_valid  = '0;
    prega_idx   = '0;
    pregb_idx   = '0;
    pdest_idx   = '0;
    prega_valid = '0;
    pregb_valid = '0;
    alu_op      = '0;
    rd_mem      = '0;
    wr_mem      = '0;
    rs_ir       = '0;
    npc         = '0;
    rob_idx     = '0;
    exfu_free   = '0;
    memfu_free  = '0;
    multfu_free = '0;
    cdb_valid   = '0;
    cdb_tag     = '0;
    entry_flush = '0;
    clear_model();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int cyc = 0; cyc < n_cycles; cyc++) begin
      drive_inputs(cyc);
      #(clk_period/4);  // Let the issue logic settle
      predict_outputs();
      compare_outputs();
      advance_model();
      @(negedge clk);
    end
    $display("%0d issues matched the model", issued);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #((n_cycles + 8 + 20) * clk_period);
    $display("Timeout: the test loop did not reach its end");
    $display("Simulation FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: filelist.f
+incdir+bench
verilog/rs_pkg.sv
verilog/rs_entry.sv
verilog/rs_bank.sv
verilog/super_rs.sv
bench/super_rs_props.sv
bench/super_rs_tb.sv

// File: verilog/rs_bank.sv
`timescale 1ns/1ps

module rs_bank (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  en,
  input  logic [rs_pkg::prf_idx-1:0]            prega_idx,
  input  logic [rs_pkg::prf_idx-1:0]            pregb_idx,
  input  logic [rs_pkg::prf_idx-1:0]            pdest_idx,
  input  logic                                  prega_valid,
  input  logic                                  pregb_valid,
  input  logic                                  rd_mem,
  input  logic                                  wr_mem,
  input  logic [rs_pkg::alu_op_w-1:0]           alu_op,
  input  logic [31:0]                           ir,
  input  logic [63:0]                           npc,
  input  logic [rs_pkg::rob_idx_w-1:0]          rob_idx,
  input  logic [rs_pkg::scalar-1:0]             cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] cdb_tag,
  input  logic [rs_pkg::rs_sz-1:0]              entry_flush,
  input  logic                                  alu_free,
  input  logic                                  mem_free,
  input  logic                                  mult_free,
  output logic                                  rs_free,
  output logic                                  alu_rdy,
  output logic                                  mem_rdy,
  output logic                                  mult_rdy,
  output logic                                  en_out,
  output rs_pkg::fu_class_t                     fu_class_out,
  output logic [rs_pkg::prf_idx-1:0]            pdest_idx_out,
  output logic [rs_pkg::prf_idx-1:0]            prega_idx_out,
  output logic [rs_pkg::prf_idx-1:0]            pregb_idx_out,
  output logic [rs_pkg::alu_op_w-1:0]           alu_op_out,
  output logic                                  rd_mem_out,
  output logic                                  wr_mem_out,
  output logic [31:0]                           ir_out,
  output logic [63:0]                           npc_out,
  output logic [rs_pkg::rob_idx_w-1:0]          rob_idx_out,
  output logic [rs_pkg::rs_idx-1:0]             rs_idx_out
);
  import rs_pkg::*;

  logic [rs_sz-1:0]     busy, ready, load, clear, elig;
  logic [rs_sz-1:0]     alu_vec, mem_vec, mult_vec, pick_vec;
  logic [rs_sz-1:0]     rd_mem_q, wr_mem_q;
  fu_class_t            cls       [rs_sz];
  logic [prf_idx-1:0]   prega_q   [rs_sz];
  logic [prf_idx-1:0]   pregb_q   [rs_sz];
  logic [prf_idx-1:0]   pdest_q   [rs_sz];
  logic [alu_op_w-1:0]  alu_op_q  [rs_sz];
  logic [31:0]          ir_q      [rs_sz];
  logic [63:0]          npc_q     [rs_sz];
  logic [rob_idx_w-1:0] rob_q     [rs_sz];
  logic [rs_idx-1:0]    alloc_idx, issue_idx;
  logic                 alloc_ok;

  // Lowest free entry
  always_comb begin
    alloc_idx = '0;
    alloc_ok  = 1'b0;
    for (int i = rs_sz - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        alloc_idx = rs_idx'(i);
        alloc_ok  = 1'b1;
      end
    end
  end

  assign rs_free = alloc_ok;  // Issuing entries still count as busy
  assign elig    = ready & ~entry_flush;

  for (genvar i = 0; i < rs_sz; i++) begin : g_entry
    assign load[i]     = en && alloc_ok && alloc_idx == i;
    assign clear[i]    = entry_flush[i] || (en_out && issue_idx == i);
    assign alu_vec[i]  = elig[i] && cls[i] == fu_alu;
    assign mem_vec[i]  = elig[i] && cls[i] == fu_mem;
    assign mult_vec[i] = elig[i] && cls[i] == fu_mult;

    rs_entry u_entry (
      .clk         (clk),
      .reset       (reset),
      .load        (load[i]),
      .clear       (clear[i]),
      .prega_idx   (prega_idx),
      .pregb_idx   (pregb_idx),
      .pdest_idx   (pdest_idx),
      .prega_valid (prega_valid),
      .pregb_valid (pregb_valid),
      .rd_mem      (rd_mem),
      .wr_mem      (wr_mem),
      .alu_op      (alu_op),
      .ir          (ir),
      .npc         (npc),
      .rob_idx     (rob_idx),
      .cdb_valid   (cdb_valid),
      .cdb_tag     (cdb_tag),
      .busy        (busy[i]),
      .ready       (ready[i]),
      .fu_class    (cls[i]),
      .prega_idx_q (prega_q[i]),
      .pregb_idx_q (pregb_q[i]),
      .pdest_idx_q (pdest_q[i]),
      .rd_mem_q    (rd_mem_q[i]),
      .wr_mem_q    (wr_mem_q[i]),
      .alu_op_q    (alu_op_q[i]),
      .ir_q        (ir_q[i]),
      .npc_q       (npc_q[i]),
      .rob_idx_q   (rob_q[i])
    );
  end

  assign alu_rdy  = |alu_vec;
  assign mem_rdy  = |mem_vec;
  assign mult_rdy = |mult_vec;

  // Mult first, then mem, then alu
  always_comb begin
    if (mult_free && mult_rdy) pick_vec = mult_vec;
    else if (mem_free && mem_rdy) pick_vec = mem_vec;
    else if (alu_free && alu_rdy) pick_vec = alu_vec;
    else pick_vec = '0;
  end

  always_comb begin
    issue_idx = '0;
    for (int i = rs_sz - 1; i >= 0; i--) begin
      if (pick_vec[i]) issue_idx = rs_idx'(i);
    end
  end

  assign en_out        = |pick_vec;
  assign rs_idx_out    = issue_idx;
  assign fu_class_out  = cls[issue_idx];
  assign pdest_idx_out = pdest_q[issue_idx];
  assign prega_idx_out = prega_q[issue_idx];
  assign pregb_idx_out = pregb_q[issue_idx];
  assign alu_op_out    = alu_op_q[issue_idx];
  assign rd_mem_out    = rd_mem_q[issue_idx];
  assign wr_mem_out    = wr_mem_q[issue_idx];
  assign ir_out        = ir_q[issue_idx];
  assign npc_out       = npc_q[issue_idx];
  assign rob_idx_out   = rob_q[issue_idx];

endmodule

// File: verilog/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  load,
  input  logic                                  clear,
  input  logic [rs_pkg::prf_idx-1:0]            prega_idx,
  input  logic [rs_pkg::prf_idx-1:0]            pregb_idx,
  input  logic [rs_pkg::prf_idx-1:0]            pdest_idx,
  input  logic                                  prega_valid,
  input  logic                                  pregb_valid,
  input  logic                                  rd_mem,
  input  logic                                  wr_mem,
  input  logic [rs_pkg::alu_op_w-1:0]           alu_op,
  input  logic [31:0]                           ir,
  input  logic [63:0]                           npc,
  input  logic [rs_pkg::rob_idx_w-1:0]          rob_idx,
  input  logic [rs_pkg::scalar-1:0]             cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0] cdb_tag,
  output logic                                  busy,
  output logic                                  ready,
  output rs_pkg::fu_class_t                     fu_class,
  output logic [rs_pkg::prf_idx-1:0]            prega_idx_q,
  output logic [rs_pkg::prf_idx-1:0]            pregb_idx_q,
  output logic [rs_pkg::prf_idx-1:0]            pdest_idx_q,
  output logic                                  rd_mem_q,
  output logic                                  wr_mem_q,
  output logic [rs_pkg::alu_op_w-1:0]           alu_op_q,
  output logic [31:0]                           ir_q,
  output logic [63:0]                           npc_q,
  output logic [rs_pkg::rob_idx_w-1:0]          rob_idx_q
);
  import rs_pkg::*;

  logic      a_valid, b_valid;
  fu_class_t class_in;

  // Any CDB lane carrying this tag
  function automatic logic cdb_hit(input logic [prf_idx-1:0] tag);
    logic hit;
    hit = 1'b0;
    for (int j = 0; j < scalar; j++) begin
      if (cdb_valid[j] && cdb_tag[j*prf_idx +: prf_idx] == tag) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_comb begin
    if (rd_mem || wr_mem) class_in = fu_mem;
    else if (alu_op == op_mulq) class_in = fu_mult;
    else class_in = fu_alu;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      a_valid <= 1'b0;
      b_valid <= 1'b0;
    end else if (clear) begin
      busy <= 1'b0;  // Issue or flush
    end else if (load) begin
      busy    <= 1'b1;
      a_valid <= prega_valid | cdb_hit(prega_idx);  // Catch a broadcast this cycle
      b_valid <= pregb_valid | cdb_hit(pregb_idx);
    end else if (busy) begin
      a_valid <= a_valid | cdb_hit(prega_idx_q);
      b_valid <= b_valid | cdb_hit(pregb_idx_q);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      prega_idx_q <= prega_idx;
      pregb_idx_q <= pregb_idx;
      pdest_idx_q <= pdest_idx;
      rd_mem_q    <= rd_mem;
      wr_mem_q    <= wr_mem;
      alu_op_q    <= alu_op;
      ir_q        <= ir;
      npc_q       <= npc;
      rob_idx_q   <= rob_idx;
      fu_class    <= class_in;
    end
  end

  assign ready = busy & a_valid & b_valid;

endmodule

// File: verilog/rs_pkg.sv
package rs_pkg;

  // Machine width
  localparam int scalar = 2;

  // Tag and index widths
  localparam int prf_idx   = 6;
  localparam int rob_idx_w = 5;
  localparam int alu_op_w  = 5;

  // Entries per bank
  localparam int rs_sz  = 4;
  localparam int rs_idx = 2;

  localparam logic [alu_op_w-1:0] op_mulq = 5'h0c;  // Goes to the multiplier

  // Functional unit classes
  typedef enum logic [1:0] {
    fu_alu,
    fu_mem,
    fu_mult
  } fu_class_t;

endpackage

// File: verilog/super_rs.sv
`timescale 1ns/1ps

module super_rs (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [rs_pkg::scalar-1:0]                 inst_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   prega_idx,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   pregb_idx,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   pdest_idx,
  input  logic [rs_pkg::scalar-1:0]                 prega_valid,
  input  logic [rs_pkg::scalar-1:0]                 pregb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::alu_op_w-1:0]  alu_op,
  input  logic [rs_pkg::scalar-1:0]                 rd_mem,
  input  logic [rs_pkg::scalar-1:0]                 wr_mem,
  input  logic [rs_pkg::scalar*32-1:0]              rs_ir,
  input  logic [rs_pkg::scalar*64-1:0]              npc,
  input  logic [rs_pkg::scalar*rs_pkg::rob_idx_w-1:0] rob_idx,
  input  logic [rs_pkg::scalar-1:0]                 exfu_free,
  input  logic [rs_pkg::scalar-1:0]                 memfu_free,
  input  logic [rs_pkg::scalar-1:0]                 multfu_free,
  input  logic [rs_pkg::scalar-1:0]                 cdb_valid,
  input  logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   cdb_tag,
  input  logic [rs_pkg::scalar*rs_pkg::rs_sz-1:0]     entry_flush,
  output logic [rs_pkg::scalar-1:0]                 rs_stall,
  output logic [rs_pkg::scalar-1:0]                 en_out,
  output rs_pkg::fu_class_t [rs_pkg::scalar-1:0]    fu_class_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   pdest_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   prega_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::prf_idx-1:0]   pregb_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::alu_op_w-1:0]  alu_op_out,
  output logic [rs_pkg::scalar-1:0]                 rd_mem_out,
  output logic [rs_pkg::scalar-1:0]                 wr_mem_out,
  output logic [rs_pkg::scalar*32-1:0]              rs_ir_out,
  output logic [rs_pkg::scalar*64-1:0]              npc_out,
  output logic [rs_pkg::scalar*rs_pkg::rob_idx_w-1:0] rob_idx_out,
  output logic [rs_pkg::scalar*rs_pkg::rs_idx-1:0]    rs_idx_out
);
  import rs_pkg::*;

  logic [scalar-1:0]    rs_free, bank_en, src_slot;
  logic [scalar-1:0]    alu_rdy, mem_rdy, mult_rdy;
  logic [scalar-1:0]    alu_go, mem_go, mult_go;
  logic [scalar-1:0]    st_prega_valid, st_pregb_valid, st_rd_mem, st_wr_mem;
  logic [prf_idx-1:0]   st_prega  [scalar];
  logic [prf_idx-1:0]   st_pregb  [scalar];
  logic [prf_idx-1:0]   st_pdest  [scalar];
  logic [alu_op_w-1:0]  st_alu_op [scalar];
  logic [31:0]          st_ir     [scalar];
  logic [63:0]          st_npc    [scalar];
  logic [rob_idx_w-1:0] st_rob    [scalar];

  assign rs_stall = ~rs_free;

  // Bank 1 takes slot 0 when bank 0 is full
  assign bank_en[0] = rs_free[0] & inst_valid[0];
  assign bank_en[1] = rs_free[1] & (inst_valid[1] | (inst_valid[0] & ~rs_free[0]));
  assign src_slot   = {rs_free[0], 1'b0};

  for (genvar b = 0; b < scalar; b++) begin : g_steer
    assign st_prega[b]       = prega_idx[src_slot[b]*prf_idx +: prf_idx];
    assign st_pregb[b]       = pregb_idx[src_slot[b]*prf_idx +: prf_idx];
    assign st_pdest[b]       = pdest_idx[src_slot[b]*prf_idx +: prf_idx];
    assign st_alu_op[b]      = alu_op[src_slot[b]*alu_op_w +: alu_op_w];
    assign st_ir[b]          = rs_ir[src_slot[b]*32 +: 32];
    assign st_npc[b]         = npc[src_slot[b]*64 +: 64];
    assign st_rob[b]         = rob_idx[src_slot[b]*rob_idx_w +: rob_idx_w];
    assign st_prega_valid[b] = prega_valid[src_slot[b]];
    assign st_pregb_valid[b] = pregb_valid[src_slot[b]];
    assign st_rd_mem[b]      = rd_mem[src_slot[b]];
    assign st_wr_mem[b]      = wr_mem[src_slot[b]];
  end

  // Unit 1 of a class goes to bank 1 only when bank 0 claims unit 0
  assign alu_go[0]  = exfu_free[0] & alu_rdy[0];
  assign mem_go[0]  = memfu_free[0] & mem_rdy[0];
  assign mult_go[0] = multfu_free[0] & mult_rdy[0];
  assign alu_go[1]  = (alu_go[0] ? exfu_free[1] : exfu_free[0]) & alu_rdy[1];
  assign mem_go[1]  = (mem_go[0] ? memfu_free[1] : memfu_free[0]) & mem_rdy[1];
  assign mult_go[1] = (mult_go[0] ? multfu_free[1] : multfu_free[0]) & mult_rdy[1];

  rs_bank rs0 (
    .clk           (clk),
    .reset         (reset),
    .en            (bank_en[0]),
    .prega_idx     (st_prega[0]),
    .pregb_idx     (st_pregb[0]),
    .pdest_idx     (st_pdest[0]),
    .prega_valid   (st_prega_valid[0]),
    .pregb_valid   (st_pregb_valid[0]),
    .rd_mem        (st_rd_mem[0]),
    .wr_mem        (st_wr_mem[0]),
    .alu_op        (st_alu_op[0]),
    .ir            (st_ir[0]),
    .npc           (st_npc[0]),
    .rob_idx       (st_rob[0]),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .entry_flush   (entry_flush[0 +: rs_sz]),
    .alu_free      (alu_go[0]),
    .mem_free      (mem_go[0]),
    .mult_free     (mult_go[0]),
    .rs_free       (rs_free[0]),
    .alu_rdy       (alu_rdy[0]),
    .mem_rdy       (mem_rdy[0]),
    .mult_rdy      (mult_rdy[0]),
    .en_out        (en_out[0]),
    .fu_class_out  (fu_class_out[0]),
    .pdest_idx_out (pdest_idx_out[0 +: prf_idx]),
    .prega_idx_out (prega_idx_out[0 +: prf_idx]),
    .pregb_idx_out (pregb_idx_out[0 +: prf_idx]),
    .alu_op_out    (alu_op_out[0 +: alu_op_w]),
    .rd_mem_out    (rd_mem_out[0]),
    .wr_mem_out    (wr_mem_out[0]),
    .ir_out        (rs_ir_out[0 +: 32]),
    .npc_out       (npc_out[0 +: 64]),
    .rob_idx_out   (rob_idx_out[0 +: rob_idx_w]),
    .rs_idx_out    (rs_idx_out[0 +: rs_idx])
  );

  rs_bank rs1 (
    .clk           (clk),
    .reset         (reset),
    .en            (bank_en[1]),
    .prega_idx     (st_prega[1]),
    .pregb_idx     (st_pregb[1]),
    .pdest_idx     (st_pdest[1]),
    .prega_valid   (st_prega_valid[1]),
    .pregb_valid   (st_pregb_valid[1]),
    .rd_mem        (st_rd_mem[1]),
    .wr_mem        (st_wr_mem[1]),
    .alu_op        (st_alu_op[1]),
    .ir            (st_ir[1]),
    .npc           (st_npc[1]),
    .rob_idx       (st_rob[1]),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag),
    .entry_flush   (entry_flush[rs_sz +: rs_sz]),
    .alu_free      (alu_go[1]),
    .mem_free      (mem_go[1]),
    .mult_free     (mult_go[1]),
    .rs_free       (rs_free[1]),
    .alu_rdy       (alu_rdy[1]),
    .mem_rdy       (mem_rdy[1]),
    .mult_rdy      (mult_rdy[1]),
    .en_out        (en_out[1]),
    .fu_class_out  (fu_class_out[1]),
    .pdest_idx_out (pdest_idx_out[prf_idx +: prf_idx]),
    .prega_idx_out (prega_idx_out[prf_idx +: prf_idx]),
    .pregb_idx_out (pregb_idx_out[prf_idx +: prf_idx]),
    .alu_op_out    (alu_op_out[alu_op_w +: alu_op_w]),
    .rd_mem_out    (rd_mem_out[1]),
    .wr_mem_out    (wr_mem_out[1]),
    .ir_out        (rs_ir_out[32 +: 32]),
    .npc_out       (npc_out[64 +: 64]),
    .rob_idx_out   (rob_idx_out[rob_idx_w +: rob_idx_w]),
    .rs_idx_out    (rs_idx_out[rs_idx +: rs_idx])
  );

endmodule
